//--- verilog.f
+incdir+include
hw/max_pkg.sv
hw/max_axil_bridge.sv
hw/max_pla.sv
hw/max_mem_bank.sv
hw/max_bus_top.sv
tests/max_bus_props.sv
tests/max_bus_tb.sv

//--- Bender.yml
package:
  name: max_bus

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/max_pkg.sv
      - hw/max_axil_bridge.sv
      - hw/max_pla.sv
      - hw/max_mem_bank.sv
      - hw/max_bus_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/max_bus_props.sv
      - tests/max_bus_tb.sv

//--- tests/max_bus_tb.sv
`timescale 1ns/1ps
`include "max_cfg.svh"

module max_bus_tb;
	localparam int NUM_TXN = 203; // All AXI transactions over every test
	localparam int TIMEOUT_NS = NUM_TXN * 20 * 4 + 400;

	logic clk_cpu;
	logic reset;
	logic [`MAX_AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`MAX_AXI_DATA_W-1:0] wdata;
	logic [`MAX_AXI_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`MAX_AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`MAX_AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [7:0] ram_model [`MAX_RAM_WORDS];
	logic [3:0] col_model [`MAX_COLRAM_WORDS];
	logic [31:0] rng = 32'd7479; // Seed
	int pass_count;
	int fail_count;

	max_bus_top max_bus_top_inst (.*);

	initial begin
		clk_cpu = 1'b0;
		forever #2 clk_cpu = ~clk_cpu;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog: run did not finish within %0d ns, a handshake never completed",
			TIMEOUT_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic is_mapped(input logic [15:0] addr);
		return addr <= `MAX_RAM_TOP || (addr >= `MAX_COLRAM_BASE && addr <= `MAX_COLRAM_TOP);
	endfunction

	// Byte the memory map should return
	function automatic logic [7:0] expected_byte(input logic [15:0] addr);
		if (addr <= `MAX_RAM_TOP)
			return ram_model[addr[10:0]]; // 2 KB mirrored
		if (is_mapped(addr))
			return {4'hF, col_model[addr[9:0]]};
		return `MAX_OPEN_BUS;
	endfunction

	function automatic logic [1:0] expected_resp(input logic [15:0] addr);
		return is_mapped(addr) ? max_pkg::RESP_OKAY : max_pkg::RESP_DECERR;
	endfunction

	function automatic void model_store(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [7:0] lane_byte;
		lane_byte = data[8*addr[1:0] +: 8];
		if (!strb[addr[1:0]])
			return; // Lane not enabled
		if (addr <= `MAX_RAM_TOP)
			ram_model[addr[10:0]] = lane_byte;
		else if (is_mapped(addr))
			col_model[addr[9:0]] = lane_byte[3:0];
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual === expected) begin
			pass_count++;
		end else begin
			fail_count++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int hold, output logic [1:0] resp);
		@(negedge clk_cpu);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (hold == 0);
		#1; // Ready settles after the falling edge
		while (!awready) begin
			@(negedge clk_cpu);
			#1;
		end
		check("wready", 1'b1, wready); // Rises with awready
		@(negedge clk_cpu);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge clk_cpu);
		repeat (hold)
			@(negedge clk_cpu);
		if (hold > 0)
			check("write_hold", 1'b1, bvalid); // Still waiting for bready
		resp = bresp;
		bready = 1'b1;
		@(negedge clk_cpu);
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [15:0] addr, input int hold,
		output logic [31:0] data, output logic [1:0] resp);
		@(negedge clk_cpu);
		araddr = addr;
		arvalid = 1'b1;
		rready = (hold == 0);
		#1;
		while (!arready) begin
			@(negedge clk_cpu);
			#1;
		end
		@(negedge clk_cpu);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk_cpu);
		repeat (hold)
			@(negedge clk_cpu);
		if (hold > 0)
			check("read_hold", 1'b1, rvalid); // Still waiting for rready
		data = rdata; // Value the host takes on the next edge
		resp = rresp;
		rready = 1'b1;
		@(negedge clk_cpu);
		rready = 1'b0;
	endtask

	task automatic write_check(input string name, input logic [15:0] addr,
		input logic [31:0] data, input logic [3:0] strb);
		logic [1:0] resp;
		axil_write(addr, data, strb, 0, resp);
		model_store(addr, data, strb);
		check(name, expected_resp(addr), resp);
	endtask

	task automatic read_check(input string name, input logic [15:0] addr, input int hold);
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(addr, hold, data, resp);
		check(name, {4{expected_byte(addr)}}, data);
		check(name, expected_resp(addr), resp);
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("%s finished, %0d mismatches", name, fail_count - fails_before);
	endtask

	task automatic test_ram_rw();
		logic [15:0] addrs [64];
		logic [31:0] r;
		int fails_before;
		fails_before = fail_count;
		foreach (addrs[i]) begin
			r = next_rand();
			addrs[i] = {5'd0, r[10:0]};
			write_check("ram_rw", addrs[i], {4{r[23:16]}}, 4'hF);
		end
		foreach (addrs[i])
			read_check("ram_rw", addrs[i], 0);
		report_test("ram_rw", fails_before);
	endtask

	task automatic test_mirror();
		logic [31:0] r;
		logic [15:0] addr;
		int fails_before;
		fails_before = fail_count;
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			addr = {5'd0, r[10:0]};
			write_check("mirror", addr, {4{r[23:16]}}, 4'hF);
			read_check("mirror", addr | 16'h0800, 0); // Upper copy of the 2 KB
		end
		report_test("mirror", fails_before);
	endtask

	task automatic test_colram();
		logic [31:0] r;
		logic [15:0] addr;
		int fails_before;
		fails_before = fail_count;
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			addr = `MAX_COLRAM_BASE | {6'd0, r[9:0]};
			write_check("colram", addr, {4{r[23:16]}}, 4'hF);
			read_check("colram", addr, 0);
		end
		report_test("colram", fails_before);
	endtask

	task automatic test_unmapped();
		logic [15:0] io_addrs [4];
		int fails_before;
		fails_before = fail_count;
		io_addrs = '{16'h2000, 16'hD000, 16'hD400, 16'hDC00}; // Open, VIC, SID, CIA
		write_check("unmapped", 16'h0000, {4{8'h5A}}, 4'hF);
		foreach (io_addrs[i]) begin
			write_check("unmapped", io_addrs[i], next_rand(), 4'hF);
			read_check("unmapped", io_addrs[i], 0);
		end
		read_check("unmapped", 16'h0000, 0); // Same offset as $2000
		report_test("unmapped", fails_before);
	endtask

	task automatic test_strobe_lane();
		logic [31:0] r;
		int fails_before;
		fails_before = fail_count;
		r = next_rand();
		write_check("strobe", 16'h0123, {4{r[7:0]}}, 4'hF);
		write_check("strobe", 16'h0123, {4{~r[7:0]}}, 4'h7); // Lane 3 disabled
		read_check("strobe", 16'h0123, 0);
		for (int lane = 0; lane < 4; lane++) begin
			write_check("lane", 16'(16'h0200 + lane), next_rand(), 4'hF);
			read_check("lane", 16'(16'h0200 + lane), 0);
		end
		report_test("strobe_lane", fails_before);
	endtask

	task automatic test_backpressure();
		logic [31:0] r;
		logic [31:0] old_word;
		logic [31:0] data;
		logic [1:0] rresp_got;
		logic [1:0] bresp_got;
		int fails_before;
		fails_before = fail_count;
		r = next_rand();
		// bready held low for 10 cycles
		axil_write(16'h0345, {4{r[7:0]}}, 4'hF, 10, bresp_got);
		model_store(16'h0345, {4{r[7:0]}}, 4'hF);
		check("backpressure", max_pkg::RESP_OKAY, bresp_got);
		read_check("backpressure", 16'h0345, 10);
		write_check("ordering", 16'h0456, {4{r[15:8]}}, 4'hF);
		old_word = {4{expected_byte(16'h0456)}};
		// Read and write offered on the same edge, read goes first
		fork
			axil_read(16'h0456, 0, data, rresp_got);
			axil_write(16'h0456, {4{~r[15:8]}}, 4'hF, 0, bresp_got);
		join
		model_store(16'h0456, {4{~r[15:8]}}, 4'hF);
		check("ordering", old_word, data);
		check("ordering", max_pkg::RESP_OKAY, rresp_got);
		check("ordering", max_pkg::RESP_OKAY, bresp_got);
		read_check("ordering", 16'h0456, 0);
		report_test("backpressure", fails_before);
	endtask

	initial begin
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		pass_count = 0;
		fail_count = 0;
		repeat (4) @(negedge clk_cpu);
		reset = 1'b0;
		test_ram_rw();
		test_mirror();
		test_colram();
		test_unmapped();
		test_strobe_lane();
		test_backpressure();
		// Failed assertions of the bound checker count as failures too
		fail_count += max_bus_top_inst.max_axil_bridge_inst.max_bus_props_inst.assert_fails;
		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- tests/max_bus_props.sv
`timescale 1ns/1ps
`include "max_cfg.svh"

module max_bus_props (
	input logic                       clk_cpu,
	input logic                       reset,
	input max_pkg::max_bus_req_t      bus_req,
	input max_pkg::max_sel_t          sel,
	input logic [1:0]                 bresp,
	input logic                       bvalid,
	input logic                       bready,
	input logic [`MAX_AXI_DATA_W-1:0] rdata,
	input logic [1:0]                 rresp,
	input logic                       rvalid,
	input logic                       rready
);
	int assert_fails = 0; // Failed assertions so far

	// PLA raises exactly one select per bus cycle
	sel_onehot: assert property (@(posedge clk_cpu) disable iff (reset)
		bus_req.valid |-> $onehot({sel.ram, sel.colram, sel.unmapped}))
		else begin
			$error("sel is not one-hot during a bus cycle");
			assert_fails++;
		end

	b_held: assert property (@(posedge clk_cpu) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("bvalid or bresp changed before the response was taken");
			assert_fails++;
		end

	r_held: assert property (@(posedge clk_cpu) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
		else begin
			$error("rvalid, rresp or rdata changed before the response was taken");
			assert_fails++;
		end

	req_pulse: assert property (@(posedge clk_cpu) disable iff (reset)
		bus_req.valid |=> !bus_req.valid) // One bus cycle only
		else begin
			$error("bus_req.valid held longer than one cycle");
			assert_fails++;
		end

endmodule

bind max_axil_bridge max_bus_props max_bus_props_inst (
	.clk_cpu (clk_cpu),
	.reset   (reset),
	.bus_req (bus_req),
	.sel     (sel),
	.bresp   (bresp),
	.bvalid  (bvalid),
	.bready  (bready),
	.rdata   (rdata),
	.rresp   (rresp),
	.rvalid  (rvalid),
	.rready  (rready)
);

//--- hw/max_bus_top.sv
`timescale 1ns/1ps
`include "max_cfg.svh"

module max_bus_top (
	input  logic                         clk_cpu,
	input  logic                         reset,
	input  logic [`MAX_AXI_ADDR_W-1:0]   awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`MAX_AXI_DATA_W-1:0]   wdata,
	input  logic [`MAX_AXI_DATA_W/8-1:0] wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [`MAX_AXI_ADDR_W-1:0]   araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [`MAX_AXI_DATA_W-1:0]   rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready
);
	max_pkg::max_bus_req_t bus_req;
	max_pkg::max_sel_t sel;
	logic [7:0] mem_rdata;

	// Host side, one bus cycle per transaction
	max_axil_bridge max_axil_bridge_inst (
		.clk_cpu   (clk_cpu),
		.reset     (reset),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.bus_req   (bus_req),
		.sel       (sel),
		.mem_rdata (mem_rdata)
	);

	max_pla max_pla_inst (
		.bus_req (bus_req),
		.sel     (sel)
	);

	max_mem_bank max_mem_bank_inst (
		.clk_cpu (clk_cpu),
		.bus_req (bus_req),
		.sel     (sel),
		.rdata   (mem_rdata)
	);

endmodule

//--- hw/max_mem_bank.sv
`timescale 1ns/1ps
`include "max_cfg.svh"

module max_mem_bank (
	input  logic                  clk_cpu,
	input  max_pkg::max_bus_req_t bus_req,
	input  max_pkg::max_sel_t     sel,
	output logic [7:0]            rdata
);
	localparam int RAM_AW = $clog2(`MAX_RAM_WORDS);
	localparam int COL_AW = $clog2(`MAX_COLRAM_WORDS);
	localparam logic [7:0] OPEN_BUS = `MAX_OPEN_BUS;

	logic [7:0] ram [`MAX_RAM_WORDS];
	logic [3:0] colram [`MAX_COLRAM_WORDS];

	logic [RAM_AW-1:0] ram_idx;
	logic [COL_AW-1:0] col_idx;
	logic [7:0] ram_q;
	logic [3:0] col_q;
	max_pkg::max_sel_t sel_q;

	// Upper offset bits ignored, so $0800 mirrors $0000
	assign ram_idx = bus_req.addr.mem.offset[RAM_AW-1:0];
	assign col_idx = bus_req.addr.mem.offset[COL_AW-1:0];

	always_ff @(posedge clk_cpu) begin
		if (bus_req.valid && bus_req.we && sel.ram)
			ram[ram_idx] <= bus_req.wdata;
		if (bus_req.valid && bus_req.we && sel.colram)
			colram[col_idx] <= bus_req.wdata[3:0]; // Only the low nibble exists
	end

	// Read side, old contents on a write cycle
	always_ff @(posedge clk_cpu) begin
		if (bus_req.valid) begin
			ram_q <= ram[ram_idx];
			col_q <= colram[col_idx];
			sel_q <= sel;
		end
	end

	always_comb begin
		if (sel_q.ram)
			rdata = ram_q;
		else if (sel_q.colram)
			rdata = {OPEN_BUS[7:4], col_q}; // Undriven upper nibble
		else
			rdata = OPEN_BUS;
	end

endmodule

//--- hw/max_pla.sv
`timescale 1ns/1ps
`include "max_cfg.svh"

module max_pla (
	input  max_pkg::max_bus_req_t bus_req,
	output max_pkg::max_sel_t     sel
);
	localparam logic [15:0] RAM_TOP = `MAX_RAM_TOP;
	localparam logic [15:0] IO_BASE = `MAX_IO_BASE;
	localparam logic [15:0] IO_TOP = `MAX_IO_TOP;
	localparam logic [15:0] COLRAM_BASE = `MAX_COLRAM_BASE;
	localparam logic [15:0] COLRAM_TOP = `MAX_COLRAM_TOP;

	logic in_ram;
	logic in_io;
	logic in_colram;

	always_comb begin
		// Page 0, mirror comes from the narrower RAM index
		in_ram = bus_req.addr.mem.page <= RAM_TOP[15:12];

		// I/O area through the chip/register view
		in_io = (bus_req.addr.io.area >= IO_BASE[15:12]) &&
			(bus_req.addr.io.area <= IO_TOP[15:12]);

		// Color RAM chip slot, all four banks
		in_colram = in_io &&
			(bus_req.addr.io.chip >= COLRAM_BASE[11:10]) &&
			(bus_req.addr.io.chip <= COLRAM_TOP[11:10]);

		sel.ram = in_ram;
		sel.colram = in_colram;
		sel.unmapped = !(in_ram || in_colram); // VIC, SID, CIA land here too
	end

endmodule

//--- hw/max_axil_bridge.sv
`timescale 1ns/1ps
`include "max_cfg.svh"

module max_axil_bridge (
	input  logic                         clk_cpu,
	input  logic                         reset,
	input  logic [`MAX_AXI_ADDR_W-1:0]   awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`MAX_AXI_DATA_W-1:0]   wdata,
	input  logic [`MAX_AXI_DATA_W/8-1:0] wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [`MAX_AXI_ADDR_W-1:0]   araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [`MAX_AXI_DATA_W-1:0]   rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready,
	output max_pkg::max_bus_req_t        bus_req,
	input  max_pkg::max_sel_t            sel,
	input  logic [7:0]                   mem_rdata
);
	localparam int LANES = `MAX_AXI_DATA_W / 8;

	typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_CAPTURE, ST_RESPOND} state_e;

	state_e state;
	logic rd_accept;
	logic wr_accept;
	logic resp_taken;
	logic [1:0] wr_lane;
	logic [7:0] wr_byte;

	logic req_valid;
	logic req_we;
	max_pkg::max_addr_u req_addr;
	logic [7:0] req_wdata;
	logic is_rd; // Current transaction is a read
	logic unmapped_q;
	max_pkg::max_resp_e resp_q;
	logic [`MAX_AXI_DATA_W-1:0] rdata_q;

	// Read wins when both are offered in the same idle cycle
	assign rd_accept = (state == ST_IDLE) && arvalid;
	assign wr_accept = (state == ST_IDLE) && awvalid && wvalid && !arvalid;
	assign arready = rd_accept;
	assign awready = wr_accept;
	assign wready = wr_accept;

	assign wr_lane = awaddr[1:0];
	assign wr_byte = wdata[8*wr_lane +: 8];

	assign resp_taken = (bvalid && bready) || (rvalid && rready);

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state <= ST_IDLE;
			req_valid <= 1'b0;
		end else begin
			req_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rd_accept || wr_accept) begin
						state <= ST_BUS;
						req_valid <= 1'b1; // One bus cycle per transaction
					end
				end
				ST_BUS: state <= ST_CAPTURE;
				ST_CAPTURE: state <= ST_RESPOND;
				ST_RESPOND: begin
					if (resp_taken)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rd_accept) begin
			is_rd <= 1'b1;
			req_we <= 1'b0;
			req_addr <= araddr;
		end else if (wr_accept) begin
			is_rd <= 1'b0;
			req_we <= wstrb[wr_lane]; // Clear strobe turns it into a dummy read
			req_addr <= awaddr;
			req_wdata <= wr_byte;
		end
		if (state == ST_BUS)
			unmapped_q <= sel.unmapped;
		if (state == ST_CAPTURE) begin
			rdata_q <= {LANES{mem_rdata}};
			resp_q <= unmapped_q ? max_pkg::RESP_DECERR : max_pkg::RESP_OKAY;
		end
	end

	assign bus_req = '{valid: req_valid, we: req_we, addr: req_addr, wdata: req_wdata};

	// Held until the host takes them
	assign bvalid = (state == ST_RESPOND) && !is_rd;
	assign rvalid = (state == ST_RESPOND) && is_rd;
	assign bresp = resp_q;
	assign rresp = resp_q;
	assign rdata = rdata_q;

endmodule

//--- hw/max_pkg.sv
package max_pkg;

	// Memory view of the CPU address
	typedef struct packed {
		logic [3:0]  page;   // 4 KB page
		logic [11:0] offset;
	} max_mem_addr_t;

	// I/O view, only meaningful in the $Dxxx area
	typedef struct packed {
		logic [3:0] area;   // $D for I/O
		logic [1:0] chip;   // VIC, SID, color RAM, CIA by address order
		logic [1:0] bank;
		logic [7:0] regsel; // Chip register
	} max_io_addr_t;

	// Same 16 address bits, two decodes
	typedef union packed {
		max_mem_addr_t mem;
		max_io_addr_t  io;
	} max_addr_u;

	// One CPU bus cycle
	typedef struct packed {
		logic      valid; // High for a single clock
		logic      we;
		max_addr_u addr;
		logic [7:0] wdata;
	} max_bus_req_t;

	// PLA chip selects, one-hot
	typedef struct packed {
		logic ram;
		logic colram;
		logic unmapped;
	} max_sel_t;

	// AXI response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_DECERR = 2'b11
	} max_resp_e;

endpackage

//--- include/max_cfg.svh
`ifndef MAX_CFG_SVH
`define MAX_CFG_SVH

// AXI4-Lite port, address width equals the CPU bus width
`define MAX_AXI_ADDR_W 16
`define MAX_AXI_DATA_W 32

// Memory sizes
`define MAX_RAM_WORDS 2048    // Main RAM bytes
`define MAX_COLRAM_WORDS 1024 // Color RAM nibbles

// RAM window, 2 KB mirrored once
`define MAX_RAM_TOP 16'h0FFF

// Color RAM inside the I/O area
`define MAX_COLRAM_BASE 16'hD800
`define MAX_COLRAM_TOP 16'hDBFF

// I/O area, VIC/SID/CIA not fitted
`define MAX_IO_BASE 16'hD000
`define MAX_IO_TOP 16'hDFFF

// Floating data bus reads as all ones
`define MAX_OPEN_BUS 8'hFF

`endif
